// ==== cart_loader.f ====
source/cart_pkg.sv
source/rom_header_probe.sv
source/cheat_code_assembler.sv
source/wram_clear_engine.sv
source/backup_ram_sequencer.sv
source/cart_loader_top.sv
verif/cart_loader_checker.sv
verif/cart_loader_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the cartridge loader testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f cart_loader.f \
	--top-module cart_loader_tb \
	-o cart_loader_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

sim_out="$(./obj_dir/cart_loader_sim 2>&1)"
sim_status=$?
echo "$sim_out"

if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_out" | grep -qx "PASS: all tests"; then
	exit 0
else
	echo "Pass message not found in simulation output"
	exit 1
fi

// ==== source/backup_ram_sequencer.sv ====
// Enables backup RAM, tracks unsaved writes and runs block-wise load and save over storage
`timescale 1ns/1ps

module backup_ram_sequencer (
	input  logic                          clk_sys,
	input  logic                          RESET,
	input  logic                          cart_dl,
	input  logic [cart_pkg::MASK_W-1:0]   ram_mask,
	input  logic                          img_mounted,
	input  logic                          img_readonly,
	input  logic                          img_size_nz,
	input  logic                          osd_open,
	input  logic                          autosave_en,
	input  logic                          bk_load_req,
	input  logic                          bk_save_req,
	input  logic                          bsram_we,
	input  logic                          sd_ack,
	output logic [cart_pkg::LBA_W-1:0]    sd_lba,
	output logic                          sd_rd,
	output logic                          sd_wr,
	output logic                          bk_busy,
	output logic                          bk_loading,
	output logic                          bk_pending
);

	cart_pkg::bk_state_e state;

	logic cart_dl_q;
	logic bk_ena;
	logic load_q;
	logic save_q;
	logic ack_q;

	logic load_now;
	logic save_now;
	logic start_load;
	logic start_save;
	logic [cart_pkg::LBA_W-1:0] last_lba;

	// Requests only count while backup RAM exists
	assign load_now = bk_load_req & bk_ena;
	assign save_now = (bk_save_req | (bk_pending & osd_open & autosave_en)) & bk_ena;

	// Image is always mounted by the end of a download, so load it then
	assign start_load = (load_now & ~load_q) | (cart_dl_q & ~cart_dl & img_size_nz & bk_ena);
	assign start_save = save_now & ~save_q;

	assign last_lba = cart_pkg::LBA_W'(ram_mask >> cart_pkg::BLOCK_SHIFT);
	assign bk_busy  = (state != cart_pkg::bk_idle);

	// ========================================
	// Enable and pending flag
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cart_dl_q  <= 1'b0;
			bk_ena     <= 1'b0;
			bk_pending <= 1'b0;
		end else begin
			cart_dl_q <= cart_dl;
			if (cart_dl && !cart_dl_q)
				bk_ena <= 1'b0;
			if (cart_dl && img_mounted && !img_readonly)
				bk_ena <= |ram_mask;

			if (bk_ena && !osd_open && bsram_we)
				bk_pending <= 1'b1;
			else if (bk_busy || !bk_ena)
				bk_pending <= 1'b0;
		end
	end

	// ========================================
	// Block transfer FSM
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			state      <= cart_pkg::bk_idle;
			load_q     <= 1'b0;
			save_q     <= 1'b0;
			ack_q      <= 1'b0;
			sd_lba     <= '0;
			sd_rd      <= 1'b0;
			sd_wr      <= 1'b0;
			bk_loading <= 1'b0;
		end else begin
			load_q <= load_now;
			save_q <= save_now;
			ack_q  <= sd_ack;
			case (state)
				cart_pkg::bk_idle: begin
					// Load wins over a save in the same cycle
					if (start_load || start_save) begin
						state      <= cart_pkg::bk_transfer;
						sd_lba     <= '0;
						bk_loading <= start_load;
						sd_rd      <= start_load;
						sd_wr      <= !start_load;
					end
				end
				cart_pkg::bk_transfer: begin
					// Storage took the request
					if (sd_ack && !ack_q) begin
						sd_rd <= 1'b0;
						sd_wr <= 1'b0;
						state <= cart_pkg::bk_wait_ack_low;
					end
				end
				cart_pkg::bk_wait_ack_low: begin
					if (!sd_ack && ack_q) begin
						if (sd_lba >= last_lba) begin
							state      <= cart_pkg::bk_idle;
							bk_loading <= 1'b0;
						end else begin
							state  <= cart_pkg::bk_transfer;
							sd_lba <= sd_lba + 1'b1;
							sd_rd  <= bk_loading;
							sd_wr  <= !bk_loading;
						end
					end
				end
				default: state <= cart_pkg::bk_idle;
			endcase
		end
	end

	rd_wr_excl_a: assert property (@(posedge clk_sys) disable iff (RESET)
		!(sd_rd && sd_wr));

endmodule

// ==== source/cart_loader_top.sv ====
// Cartridge loader top: decodes the download index and connects the four loader engines
`timescale 1ns/1ps

module cart_loader_top (
	input  logic                             clk_sys,
	input  logic                             RESET,
	input  logic                             dl_active,
	input  logic [7:0]                       dl_index,
	input  logic                             dl_wr,
	input  logic [cart_pkg::IO_ADDR_W-1:0]   dl_addr,
	input  logic [cart_pkg::IO_DATA_W-1:0]   dl_data,
	input  cart_pkg::rom_layout_e            layout,
	input  cart_pkg::region_sel_e            region_sel,
	input  cart_pkg::fill_pattern_e          fill_pattern,
	input  logic                             img_mounted,
	input  logic                             img_readonly,
	input  logic                             img_size_nz,
	input  logic                             osd_open,
	input  logic                             autosave_en,
	input  logic                             bk_load_req,
	input  logic                             bk_save_req,
	input  logic                             bsram_we,
	input  logic                             sd_ack,
	output logic [7:0]                       rom_type,
	output logic [cart_pkg::MASK_W-1:0]      rom_mask,
	output logic [cart_pkg::MASK_W-1:0]      ram_mask,
	output logic                             pal,
	output logic [cart_pkg::CODE_W-1:0]      code,
	output logic                             code_valid,
	output logic                             fill_wr,
	output logic [cart_pkg::FILL_ADDR_W-1:0] fill_addr,
	output logic [7:0]                       fill_data,
	output logic [cart_pkg::LBA_W-1:0]       sd_lba,
	output logic                             sd_rd,
	output logic                             sd_wr,
	output logic                             bk_busy,
	output logic                             bk_loading,
	output logic                             bk_pending
);

	logic cart_dl;
	logic code_dl;

	// Index decoded once for all engines
	assign cart_dl = dl_active && (dl_index == cart_pkg::CART_INDEX);
	assign code_dl = dl_active && (dl_index == cart_pkg::CODE_INDEX);

	rom_header_probe probe_i (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.cart_dl    (cart_dl),
		.dl_wr      (dl_wr),
		.dl_addr    (dl_addr),
		.dl_data    (dl_data),
		.layout     (layout),
		.region_sel (region_sel),
		.rom_type   (rom_type),
		.rom_mask   (rom_mask),
		.ram_mask   (ram_mask),
		.pal        (pal)
	);

	cheat_code_assembler cheat_i (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.code_dl    (code_dl),
		.dl_wr      (dl_wr),
		.dl_addr    (dl_addr[3:0]),
		.dl_data    (dl_data),
		.code       (code),
		.code_valid (code_valid)
	);

	wram_clear_engine wram_i (
		.clk_sys      (clk_sys),
		.RESET        (RESET),
		.cart_dl      (cart_dl),
		.fill_pattern (fill_pattern),
		.fill_wr      (fill_wr),
		.fill_addr    (fill_addr),
		.fill_data    (fill_data)
	);

	// RAM mask from the header decides the block range
	backup_ram_sequencer bk_i (
		.clk_sys      (clk_sys),
		.RESET        (RESET),
		.cart_dl      (cart_dl),
		.ram_mask     (ram_mask),
		.img_mounted  (img_mounted),
		.img_readonly (img_readonly),
		.img_size_nz  (img_size_nz),
		.osd_open     (osd_open),
		.autosave_en  (autosave_en),
		.bk_load_req  (bk_load_req),
		.bk_save_req  (bk_save_req),
		.bsram_we     (bsram_we),
		.sd_ack       (sd_ack),
		.sd_lba       (sd_lba),
		.sd_rd        (sd_rd),
		.sd_wr        (sd_wr),
		.bk_busy      (bk_busy),
		.bk_loading   (bk_loading),
		.bk_pending   (bk_pending)
	);

endmodule

// ==== source/cart_pkg.sv ====
// Shared widths, header offsets, size defaults and enums for the cartridge loader

package cart_pkg;

	// ========================================
	// Download stream
	// ========================================
	localparam int IO_ADDR_W = 25;
	localparam int IO_DATA_W = 16;

	localparam logic [7:0] CART_INDEX = 8'h00;
	localparam logic [7:0] CODE_INDEX = 8'hFF;

	// ========================================
	// ROM header
	// ========================================
	localparam int MASK_W      = 24;
	localparam int HEADER_SKIP = 512;

	// Size field per layout with the copier header included
	localparam logic [IO_ADDR_W-1:0] HDR_LO_OFS   = IO_ADDR_W'('h7FD6 + HEADER_SKIP);
	localparam logic [IO_ADDR_W-1:0] HDR_HI_OFS   = IO_ADDR_W'('hFFD6 + HEADER_SKIP);
	localparam logic [IO_ADDR_W-1:0] HDR_EXHI_OFS = IO_ADDR_W'('h40FFD6 + HEADER_SKIP);

	localparam logic [3:0] ROM_SIZE_DEFAULT = 4'd12;
	localparam int         SIZE_UNIT        = 1024;

	// ========================================
	// Backup RAM, work RAM, cheats
	// ========================================
	localparam int LBA_W       = 32;
	localparam int BLOCK_SHIFT = 9;
	localparam int FILL_ADDR_W = 17;
	localparam int CODE_W      = 128;

	typedef enum logic [2:0] {
		layout_auto,
		layout_no_header,
		layout_lorom,
		layout_hirom,
		layout_exhirom
	} rom_layout_e;

	// Power-on contents of work RAM
	typedef enum logic [1:0] {
		fill_9966,
		fill_00ff,
		fill_55,
		fill_ff
	} fill_pattern_e;

	typedef enum logic [1:0] {
		region_auto,
		region_ntsc,
		region_pal
	} region_sel_e;

	typedef enum logic [1:0] {
		bk_idle,
		bk_transfer,
		bk_wait_ack_low
	} bk_state_e;

endpackage

// ==== source/cheat_code_assembler.sv ====
// Collects eight cheat-code words into one 128-bit code and strobes it when complete
`timescale 1ns/1ps

module cheat_code_assembler (
	input  logic                           clk_sys,
	input  logic                           RESET,
	input  logic                           code_dl,
	input  logic                           dl_wr,
	input  logic [3:0]                     dl_addr,
	input  logic [cart_pkg::IO_DATA_W-1:0] dl_data,
	output logic [cart_pkg::CODE_W-1:0]    code,
	output logic                           code_valid
);

	// Flags 127:96, address 95:64, compare 63:32, replace 31:0
	always_ff @(posedge clk_sys) begin
		if (code_dl && dl_wr) begin
			case (dl_addr)
				4'd0:  code[111:96]  <= dl_data;
				4'd2:  code[127:112] <= dl_data;
				4'd4:  code[79:64]   <= dl_data;
				4'd6:  code[95:80]   <= dl_data;
				4'd8:  code[47:32]   <= dl_data;
				4'd10: code[63:48]   <= dl_data;
				4'd12: code[15:0]    <= dl_data;
				4'd14: code[31:16]   <= dl_data;
				default: ;
			endcase
		end
	end

	// Last word of the record
	always_ff @(posedge clk_sys) begin
		if (RESET)
			code_valid <= 1'b0;
		else
			code_valid <= code_dl && dl_wr && (dl_addr == 4'd14);
	end

	valid_pulse_a: assert property (@(posedge clk_sys) disable iff (RESET)
		code_valid |=> !code_valid);

endmodule

// ==== source/rom_header_probe.sv ====
// Watches cartridge download words and registers mapper type, ROM/RAM masks and video region
`timescale 1ns/1ps

module rom_header_probe (
	input  logic                               clk_sys,
	input  logic                               RESET,
	input  logic                               cart_dl,
	input  logic                               dl_wr,
	input  logic [cart_pkg::IO_ADDR_W-1:0]     dl_addr,
	input  logic [cart_pkg::IO_DATA_W-1:0]     dl_data,
	input  cart_pkg::rom_layout_e              layout,
	input  cart_pkg::region_sel_e              region_sel,
	output logic [7:0]                         rom_type,
	output logic [cart_pkg::MASK_W-1:0]        rom_mask,
	output logic [cart_pkg::MASK_W-1:0]        ram_mask,
	output logic                               pal
);

	logic [3:0] rom_code;
	logic [3:0] ram_code;
	logic [3:0] rom_code_nxt;
	logic [3:0] ram_code_nxt;
	logic       hdr_region;
	logic       fixed_layout;
	logic [cart_pkg::IO_ADDR_W-1:0] size_ofs;

	// 1 KB shifted by the size code
	function automatic logic [cart_pkg::MASK_W-1:0] size_to_mask(input logic [3:0] size_code);
		size_to_mask = (cart_pkg::MASK_W'(cart_pkg::SIZE_UNIT) << size_code)
			- cart_pkg::MASK_W'(1);
	endfunction

	// Where the size field lives for a forced layout
	always_comb begin
		fixed_layout = 1'b1;
		case (layout)
			cart_pkg::layout_lorom:   size_ofs = cart_pkg::HDR_LO_OFS;
			cart_pkg::layout_hirom:   size_ofs = cart_pkg::HDR_HI_OFS;
			cart_pkg::layout_exhirom: size_ofs = cart_pkg::HDR_EXHI_OFS;
			default: begin
				fixed_layout = 1'b0;
				size_ofs     = '0;
			end
		endcase
	end

	// Size codes after this word, so the masks track the deciding write directly
	always_comb begin
		rom_code_nxt = rom_code;
		ram_code_nxt = ram_code;
		if (dl_addr == '0) begin
			rom_code_nxt = cart_pkg::ROM_SIZE_DEFAULT;
			ram_code_nxt = 4'h0;
			// Auto layout carries both codes in the first byte
			if (layout == cart_pkg::layout_auto && dl_data[7:0] != 8'h00) begin
				rom_code_nxt = dl_data[3:0];
				ram_code_nxt = dl_data[7:4];
			end
		end
		if (fixed_layout) begin
			if (dl_addr == size_ofs)
				rom_code_nxt = dl_data[11:8];
			if (dl_addr == size_ofs + cart_pkg::IO_ADDR_W'(2))
				ram_code_nxt = dl_data[3:0];
		end
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			rom_code   <= cart_pkg::ROM_SIZE_DEFAULT;
			ram_code   <= 4'h0;
			rom_type   <= 8'h00;
			rom_mask   <= '0;
			ram_mask   <= '0;
			hdr_region <= 1'b0;
			pal        <= 1'b0;
		end else if (cart_dl) begin
			if (dl_wr) begin
				rom_code <= rom_code_nxt;
				ram_code <= ram_code_nxt;
				rom_mask <= size_to_mask(rom_code_nxt);
				ram_mask <= (ram_code_nxt != 4'h0) ? size_to_mask(ram_code_nxt) : '0;
				if (dl_addr == '0) begin
					case (layout)
						cart_pkg::layout_no_header: rom_type <= 8'd0;
						cart_pkg::layout_lorom:     rom_type <= 8'd0;
						cart_pkg::layout_hirom:     rom_type <= 8'd1;
						cart_pkg::layout_exhirom:   rom_type <= 8'd2;
						default:                    rom_type <= dl_data[15:8];
					endcase
				end
				if (dl_addr == cart_pkg::IO_ADDR_W'(2))
					hdr_region <= dl_data[8];
			end
		end else begin
			// Forced region overrides the header
			if (region_sel == cart_pkg::region_auto)
				pal <= hdr_region;
			else
				pal <= (region_sel == cart_pkg::region_pal);
		end
	end

	// Mapper masks are frozen outside a cartridge download
	mask_stable_a: assert property (@(posedge clk_sys) disable iff (RESET)
		!$stable({rom_mask, ram_mask}) |-> $past(cart_dl));

endmodule

// ==== source/wram_clear_engine.sv ====
// Sweeps every work-RAM address with the power-on pattern when a cartridge download starts
`timescale 1ns/1ps

module wram_clear_engine (
	input  logic                             clk_sys,
	input  logic                             RESET,
	input  logic                             cart_dl,
	input  cart_pkg::fill_pattern_e          fill_pattern,
	output logic                             fill_wr,
	output logic [cart_pkg::FILL_ADDR_W-1:0] fill_addr,
	output logic [7:0]                       fill_data
);

	logic cart_dl_q;

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cart_dl_q <= 1'b0;
			fill_wr   <= 1'b0;
			fill_addr <= '0;
		end else begin
			cart_dl_q <= cart_dl;
			if (cart_dl && !cart_dl_q) begin
				fill_wr   <= 1'b1;
				fill_addr <= '0;
			end else if (fill_wr) begin
				// Wraps back to zero after the last address
				fill_addr <= fill_addr + 1'b1;
				if (&fill_addr)
					fill_wr <= 1'b0;
			end else begin
				fill_addr <= '0;
			end
		end
	end

	// ========================================
	// Pattern generator
	// ========================================
	always_comb begin
		case (fill_pattern)
			cart_pkg::fill_9966: fill_data = (fill_addr[8] ^ fill_addr[2]) ? 8'h66 : 8'h99;
			cart_pkg::fill_00ff: fill_data = (fill_addr[9] ^ fill_addr[0]) ? 8'hFF : 8'h00;
			cart_pkg::fill_55:   fill_data = 8'h55;
			default:             fill_data = 8'hFF;
		endcase
	end

	idle_addr_a: assert property (@(posedge clk_sys) disable iff (RESET)
		!fill_wr |-> (fill_addr == '0));

endmodule

// ==== verif/cart_loader_checker.sv ====
// Checker for the cartridge loader testbench; watches DUT outputs and counts errors
`timescale 1ns/1ps

module cart_loader_checker (
	input logic                             clk_sys,
	input logic                             RESET,
	input logic                             clear_counts,
	input cart_pkg::fill_pattern_e          fill_pattern,
	input logic                             fill_wr,
	input logic [cart_pkg::FILL_ADDR_W-1:0] fill_addr,
	input logic [7:0]                       fill_data,
	input logic [cart_pkg::LBA_W-1:0]       sd_lba,
	input logic                             sd_rd,
	input logic                             sd_wr,
	input logic                             code_valid
);

	int   mismatch_cnt = 0;
	int   other_cnt = 0;
	int   fill_count;
	int   rd_count;
	int   wr_count;
	int   valid_count;
	logic rd_q;
	logic wr_q;

	task automatic check_value(input string name, input logic [127:0] expected,
		input logic [127:0] actual);
		if (expected !== actual) begin
			mismatch_cnt++;
			$display("MISMATCH %s: expected %0h actual %0h", name, expected, actual);
		end
	endtask

	task automatic note_failure(input string msg);
		other_cnt++;
		$display("ERROR: %s", msg);
	endtask

	// Power-on pattern per address
	function automatic logic [7:0] pattern_byte(input cart_pkg::fill_pattern_e pat,
		input logic [cart_pkg::FILL_ADDR_W-1:0] a);
		case (pat)
			cart_pkg::fill_9966: pattern_byte = (a[8] ^ a[2]) ? 8'h66 : 8'h99;
			cart_pkg::fill_00ff: pattern_byte = (a[9] ^ a[0]) ? 8'hFF : 8'h00;
			cart_pkg::fill_55:   pattern_byte = 8'h55;
			default:             pattern_byte = 8'hFF;
		endcase
	endfunction

	// ========================================
	// Output monitors
	// ========================================
	always @(posedge clk_sys) begin
		if (RESET || clear_counts) begin
			fill_count  <= 0;
			rd_count    <= 0;
			wr_count    <= 0;
			valid_count <= 0;
			rd_q        <= 1'b0;
			wr_q        <= 1'b0;
		end else begin
			rd_q <= sd_rd;
			wr_q <= sd_wr;
			if (fill_wr) begin
				check_value("wram fill_addr", 128'(fill_count[16:0]), 128'(fill_addr));
				check_value("wram fill_data", 128'(pattern_byte(fill_pattern, fill_addr)),
					128'(fill_data));
				fill_count <= fill_count + 1;
			end
			// Block numbers count up from zero within a transfer
			if (sd_rd && !rd_q) begin
				check_value("sd_rd lba", 128'(rd_count), 128'(sd_lba));
				rd_count <= rd_count + 1;
			end
			if (sd_wr && !wr_q) begin
				check_value("sd_wr lba", 128'(wr_count), 128'(sd_lba));
				wr_count <= wr_count + 1;
			end
			if (sd_rd && sd_wr)
				note_failure("sd_rd and sd_wr were high in the same cycle");
			if (code_valid)
				valid_count <= valid_count + 1;
		end
	end

endmodule

// ==== verif/cart_loader_tb.sv ====
// Testbench top for the cartridge loader; run it as the simulation top with the checker alongside
`timescale 1ns/1ps

module cart_loader_tb;

	typedef struct packed {
		cart_pkg::rom_layout_e   layout;
		logic [15:0]             w0;
		logic [15:0]             w2;
		logic [15:0]             size_w;
		logic [15:0]             ram_w;
		cart_pkg::region_sel_e   rsel;
		cart_pkg::fill_pattern_e pat;
		logic [7:0]              exp_type;
		logic [3:0]              exp_rom;
		logic [3:0]              exp_ram;
		logic                    exp_region;
	} row_t;

	localparam int NUM_ROWS   = 7;
	localparam int FILL_WORDS = 1 << cart_pkg::FILL_ADDR_W;

	logic                             clk_sys;
	logic                             RESET;
	logic                             dl_active;
	logic [7:0]                       dl_index;
	logic                             dl_wr;
	logic [cart_pkg::IO_ADDR_W-1:0]   dl_addr;
	logic [cart_pkg::IO_DATA_W-1:0]   dl_data;
	cart_pkg::rom_layout_e            layout;
	cart_pkg::region_sel_e            region_sel;
	cart_pkg::fill_pattern_e          fill_pattern;
	logic                             img_mounted;
	logic                             img_readonly;
	logic                             img_size_nz;
	logic                             osd_open;
	logic                             autosave_en;
	logic                             bk_load_req;
	logic                             bk_save_req;
	logic                             bsram_we;
	logic                             sd_ack = 1'b0;
	logic [7:0]                       rom_type;
	logic [cart_pkg::MASK_W-1:0]      rom_mask;
	logic [cart_pkg::MASK_W-1:0]      ram_mask;
	logic                             pal;
	logic [cart_pkg::CODE_W-1:0]      code;
	logic                             code_valid;
	logic                             fill_wr;
	logic [cart_pkg::FILL_ADDR_W-1:0] fill_addr;
	logic [7:0]                       fill_data;
	logic [cart_pkg::LBA_W-1:0]       sd_lba;
	logic                             sd_rd;
	logic                             sd_wr;
	logic                             bk_busy;
	logic                             bk_loading;
	logic                             bk_pending;
	logic                             clear_counts;

	integer seed;
	int     ack_left;
	row_t   rows [NUM_ROWS];
	string  names [NUM_ROWS];

	cart_loader_top dut_i (.*);

	cart_loader_checker chk_i (
		.clk_sys      (clk_sys),
		.RESET        (RESET),
		.clear_counts (clear_counts),
		.fill_pattern (fill_pattern),
		.fill_wr      (fill_wr),
		.fill_addr    (fill_addr),
		.fill_data    (fill_data),
		.sd_lba       (sd_lba),
		.sd_rd        (sd_rd),
		.sd_wr        (sd_wr),
		.code_valid   (code_valid)
	);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	// Global limit on run time
	initial begin
		#20_000_000;
		$display("ERROR: simulation ran past its time limit");
		$display("FAIL: see errors above");
		$finish;
	end

	// ========================================
	// Storage model with random ack length
	// ========================================
	always @(posedge clk_sys) begin
		if (RESET) begin
			sd_ack   <= 1'b0;
			ack_left <= 0;
		end else if (ack_left != 0) begin
			ack_left <= ack_left - 1;
			if (ack_left == 1)
				sd_ack <= 1'b0;
		end else if ((sd_rd || sd_wr) && !sd_ack) begin
			sd_ack   <= 1'b1;
			ack_left <= 2 + int'($unsigned($random(seed)) % 6);
		end
	end

	// Mask is 1 KB shifted left by the code minus one
	function automatic logic [cart_pkg::MASK_W-1:0] expected_mask(input logic [3:0] size_code);
		expected_mask = (cart_pkg::MASK_W'(1024) << size_code) - cart_pkg::MASK_W'(1);
	endfunction

	task automatic tick(input int n);
		repeat (n) @(posedge clk_sys);
	endtask

	task automatic write_word(input logic [24:0] addr, input logic [15:0] data);
		@(posedge clk_sys);
		dl_wr   <= 1'b1;
		dl_addr <= addr;
		dl_data <= data;
		@(posedge clk_sys);
		dl_wr   <= 1'b0;
	endtask

	task automatic cart_download(input row_t r);
		logic [24:0] ofs;
		ofs = '0;
		@(posedge clk_sys);
		clear_counts <= 1'b1;
		layout       <= r.layout;
		region_sel   <= r.rsel;
		fill_pattern <= r.pat;
		@(posedge clk_sys);
		clear_counts <= 1'b0;
		dl_index     <= cart_pkg::CART_INDEX;
		dl_active    <= 1'b1;
		write_word(25'd0, r.w0);
		write_word(25'd2, r.w2);
		case (r.layout)
			cart_pkg::layout_lorom:   ofs = cart_pkg::HDR_LO_OFS;
			cart_pkg::layout_hirom:   ofs = cart_pkg::HDR_HI_OFS;
			cart_pkg::layout_exhirom: ofs = cart_pkg::HDR_EXHI_OFS;
			default: ;
		endcase
		if (ofs != '0) begin
			write_word(ofs, r.size_w);
			write_word(ofs + 25'd2, r.ram_w);
		end
		tick(4);
		dl_active <= 1'b0;
	endtask

	task automatic wait_fill_done(input string what);
		int cycles;
		cycles = 0;
		while ((fill_wr || chk_i.fill_count == 0) && cycles < FILL_WORDS + 200) begin
			@(posedge clk_sys);
			cycles++;
		end
		if (fill_wr)
			chk_i.note_failure({"timeout waiting for the work-RAM clear in ", what});
		chk_i.check_value({what, " fill_count"}, 128'(FILL_WORDS), 128'(chk_i.fill_count));
	endtask

	task automatic wait_transfer(input string what, input logic exp_loading);
		int cycles;
		cycles = 0;
		while (!bk_busy && cycles < 200) begin
			@(posedge clk_sys);
			cycles++;
		end
		if (!bk_busy)
			chk_i.note_failure({"timeout waiting for ", what, " to start"});
		else
			chk_i.check_value({what, " bk_loading"}, 128'(exp_loading), 128'(bk_loading));
		cycles = 0;
		while (bk_busy && cycles < 10000) begin
			@(posedge clk_sys);
			cycles++;
		end
		if (bk_busy)
			chk_i.note_failure({"timeout waiting for ", what, " to finish"});
	endtask

	task automatic check_probe(input int i);
		row_t r;
		logic exp_pal;
		r = rows[i];
		tick(2);
		if (r.rsel == cart_pkg::region_auto)
			exp_pal = r.exp_region;
		else
			exp_pal = (r.rsel == cart_pkg::region_pal);
		chk_i.check_value({names[i], " rom_type"}, 128'(r.exp_type), 128'(rom_type));
		chk_i.check_value({names[i], " rom_mask"}, 128'(expected_mask(r.exp_rom)), 128'(rom_mask));
		chk_i.check_value({names[i], " ram_mask"},
			128'((r.exp_ram == 4'h0) ? '0 : expected_mask(r.exp_ram)), 128'(ram_mask));
		chk_i.check_value({names[i], " pal"}, 128'(exp_pal), 128'(pal));
	endtask

	task automatic cheat_test();
		logic [15:0] w [8];
		logic [127:0] exp_code;
		int cycles;
		for (int k = 0; k < 8; k++)
			w[k] = 16'hA100 + 16'(k * 16'h0111);
		@(posedge clk_sys);
		clear_counts <= 1'b1;
		@(posedge clk_sys);
		clear_counts <= 1'b0;
		dl_index     <= cart_pkg::CODE_INDEX;
		dl_active    <= 1'b1;
		for (int k = 0; k < 8; k++)
			write_word(25'(2 * k), w[k]);
		cycles = 0;
		while (chk_i.valid_count == 0 && cycles < 50) begin
			@(posedge clk_sys);
			cycles++;
		end
		dl_active <= 1'b0;
		tick(4);
		// Flags, address, compare, replacement; low word first in each
		exp_code = {w[1], w[0], w[3], w[2], w[5], w[4], w[7], w[6]};
		chk_i.check_value("cheat code_valid pulses", 128'(1), 128'(chk_i.valid_count));
		chk_i.check_value("cheat code", exp_code, code);
	endtask

	initial begin
		seed = 32'h8851;
		// Name, layout, w0, w2, size word, ram word, region, pattern, type, rom, ram, hdr region
		names[0] = "auto_hdr";
		rows[0]  = {cart_pkg::layout_auto, 16'h0335, 16'h0100, 16'h0000, 16'h0000,
			cart_pkg::region_auto, cart_pkg::fill_9966, 8'd3, 4'd5, 4'd3, 1'b1};
		names[1] = "no_header";
		rows[1]  = {cart_pkg::layout_no_header, 16'h1234, 16'h0000, 16'h0000, 16'h0000,
			cart_pkg::region_pal, cart_pkg::fill_00ff, 8'd0, 4'd12, 4'd0, 1'b0};
		names[2] = "lorom";
		rows[2]  = {cart_pkg::layout_lorom, 16'h0000, 16'h0100, 16'h0A00, 16'h0001,
			cart_pkg::region_auto, cart_pkg::fill_55, 8'd0, 4'd10, 4'd1, 1'b1};
		names[3] = "hirom";
		rows[3]  = {cart_pkg::layout_hirom, 16'h0000, 16'h0000, 16'h0B00, 16'h0003,
			cart_pkg::region_ntsc, cart_pkg::fill_ff, 8'd1, 4'd11, 4'd3, 1'b0};
		names[4] = "exhirom";
		rows[4]  = {cart_pkg::layout_exhirom, 16'h0000, 16'h0100, 16'h0D00, 16'h0005,
			cart_pkg::region_auto, cart_pkg::fill_9966, 8'd2, 4'd13, 4'd5, 1'b1};
		names[5] = "auto_zero";
		rows[5]  = {cart_pkg::layout_auto, 16'h0000, 16'h0000, 16'h0000, 16'h0000,
			cart_pkg::region_auto, cart_pkg::fill_00ff, 8'd0, 4'd12, 4'd0, 1'b0};
		names[6] = "autoload";
		rows[6]  = {cart_pkg::layout_lorom, 16'h0000, 16'h0000, 16'h0A00, 16'h0003,
			cart_pkg::region_ntsc, cart_pkg::fill_55, 8'd0, 4'd10, 4'd3, 1'b0};

		RESET        = 1'b1;
		dl_active    = 1'b0;
		dl_index     = 8'h00;
		dl_wr        = 1'b0;
		dl_addr      = '0;
		dl_data      = '0;
		layout       = cart_pkg::layout_auto;
		region_sel   = cart_pkg::region_auto;
		fill_pattern = cart_pkg::fill_9966;
		img_mounted  = 1'b0;
		img_readonly = 1'b0;
		img_size_nz  = 1'b0;
		osd_open     = 1'b0;
		autosave_en  = 1'b0;
		bk_load_req  = 1'b0;
		bk_save_req  = 1'b0;
		bsram_we     = 1'b0;
		clear_counts = 1'b0;
		tick(3);
		RESET <= 1'b0;
		tick(2);

		// Header probe and work-RAM clear over the table
		for (int i = 0; i < 6; i++) begin
			cart_download(rows[i]);
			check_probe(i);
			wait_fill_done(names[i]);
		end

		cheat_test();

		// Automatic load after a mounted download
		@(posedge clk_sys);
		img_mounted <= 1'b1;
		img_size_nz <= 1'b1;
		cart_download(rows[6]);
		wait_transfer("automatic load", 1'b1);
		check_probe(6);
		chk_i.check_value("autoload blocks",
			128'((expected_mask(4'd3) >> cart_pkg::BLOCK_SHIFT) + 1), 128'(chk_i.rd_count));
		chk_i.check_value("autoload sd_wr count", 128'(0), 128'(chk_i.wr_count));
		chk_i.check_value("autoload bk_loading", 128'(0), 128'(bk_loading));
		wait_fill_done(names[6]);

		// Pending flag then autosave on menu open
		@(posedge clk_sys);
		clear_counts <= 1'b1;
		@(posedge clk_sys);
		clear_counts <= 1'b0;
		bsram_we     <= 1'b1;
		@(posedge clk_sys);
		bsram_we <= 1'b0;
		tick(2);
		chk_i.check_value("pending bk_pending set", 128'(1), 128'(bk_pending));
		osd_open    <= 1'b1;
		autosave_en <= 1'b1;
		wait_transfer("autosave", 1'b0);
		tick(2);
		chk_i.check_value("autosave blocks",
			128'((expected_mask(4'd3) >> cart_pkg::BLOCK_SHIFT) + 1), 128'(chk_i.wr_count));
		chk_i.check_value("autosave sd_rd count", 128'(0), 128'(chk_i.rd_count));
		chk_i.check_value("autosave bk_pending cleared", 128'(0), 128'(bk_pending));
		osd_open <= 1'b0;

		// Without backup RAM the requests are ignored
		cart_download(rows[1]);
		check_probe(1);
		wait_fill_done("no_backup");
		@(posedge clk_sys);
		bk_load_req <= 1'b1;
		bk_save_req <= 1'b1;
		tick(3);
		bk_load_req <= 1'b0;
		bk_save_req <= 1'b0;
		tick(50);
		chk_i.check_value("no_backup sd_rd count", 128'(0), 128'(chk_i.rd_count));
		chk_i.check_value("no_backup sd_wr count", 128'(0), 128'(chk_i.wr_count));

		$display("Error counts: %0d mismatches, %0d other failures",
			chk_i.mismatch_cnt, chk_i.other_cnt);
		if (chk_i.mismatch_cnt + chk_i.other_cnt == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule
